// File: verilog/l3c_pkg.sv
package l3c_pkg;

    localparam int GLB_AW  = 10;
    localparam int WORD_W  = 32;
    localparam int CNT_W   = 8;
    localparam int SCALE_W = 16;

    typedef logic [WORD_W-1:0]  word_t;      // glb, fifo and product data
    typedef logic [GLB_AW-1:0]  glb_addr_t;  // glb word address
    typedef logic [CNT_W-1:0]   cnt_t;       // words per lane
    typedef logic [SCALE_W-1:0] scale_t;     // pe multiplier

    // job level control
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_e;

    // lane regions sit back to back, lane l starts l*len words past base
    function automatic glb_addr_t lane_region(
        glb_addr_t   base,
        int unsigned lane,
        cnt_t        len
    );
        return base + glb_addr_t'(lane) * glb_addr_t'(len);
    endfunction

endpackage

// File: verilog/glb_wb_if.sv
`timescale 1ns/100ps

interface glb_wb_if import l3c_pkg::*; ();

    logic      cyc;
    logic      stb;
    logic      we;
    glb_addr_t adr;
    word_t     dat_w;
    word_t     dat_r;   // valid with ack
    logic      ack;     // single cycle

    // lane controllers
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // glb arbiter side
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: verilog/lane_fifo.sv
`timescale 1ns/100ps

module lane_fifo import l3c_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  push_i,
    input  word_t wdata_i,
    input  logic  pop_i,
    output word_t rdata_o,
    output logic  empty_o,
    output logic  afull_o
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    word_t         mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] cnt_q;

    function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] ptr);
        return (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rdata_o = mem[rd_ptr_q];  // head shows without pop
    assign empty_o = (cnt_q == '0);
    assign afull_o = (cnt_q >= CW'(FIFO_DEPTH - 1));  // one slot left

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // both or neither
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        pop_i |-> !empty_o);
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        push_i |-> (cnt_q != CW'(FIFO_DEPTH)));

endmodule

// File: verilog/glb_sram_arb.sv
`timescale 1ns/100ps

module glb_sram_arb import l3c_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      host_cyc_i,
    input  logic      host_stb_i,
    input  logic      host_we_i,
    input  glb_addr_t host_adr_i,
    input  word_t     host_dat_i,
    output word_t     host_dat_o,
    output logic      host_ack_o,
    glb_wb_if.slave   lane_bus [2*NUM_LANES]
);

    localparam int NM = 2 * NUM_LANES;  // ifmap readers then opsum writers
    localparam int RW = $clog2(NM);

    word_t         mem [2**GLB_AW];
    word_t         rd_q;
    logic          host_ack_q;
    logic [NM-1:0] lane_ack_q;
    logic [RW-1:0] rr_q;              // first lane to look at

    logic [NM-1:0] lane_req;
    logic [NM-1:0] lane_we;
    glb_addr_t     lane_adr [NM];
    word_t         lane_wdat [NM];
    logic          lane_found;
    logic [RW-1:0] lane_pick;
    logic          idle;
    logic          host_sel;
    logic          lane_sel;
    logic          acc_we;
    glb_addr_t     acc_adr;
    word_t         acc_wdat;

    for (genvar p = 0; p < NM; p++) begin : g_port
        assign lane_req[p]       = lane_bus[p].cyc & lane_bus[p].stb;
        assign lane_we[p]        = lane_bus[p].we;
        assign lane_adr[p]       = lane_bus[p].adr;
        assign lane_wdat[p]      = lane_bus[p].dat_w;
        assign lane_bus[p].ack   = lane_ack_q[p];
        assign lane_bus[p].dat_r = rd_q;
    end

    // round robin from rr_q
    always_comb begin
        lane_found = 1'b0;
        lane_pick  = rr_q;
        for (int k = 0; k < NM; k++) begin
            if (!lane_found && lane_req[(int'(rr_q) + k) % NM]) begin
                lane_found = 1'b1;
                lane_pick  = RW'((int'(rr_q) + k) % NM);
            end
        end
    end

    // no new grant while an ack is out, stb is still up then
    assign idle     = !host_ack_q && (lane_ack_q == '0);
    assign host_sel = idle && host_cyc_i && host_stb_i;  // host wins
    assign lane_sel = idle && !host_sel && lane_found;

    assign acc_we   = host_sel ? host_we_i  : lane_we[lane_pick];
    assign acc_adr  = host_sel ? host_adr_i : lane_adr[lane_pick];
    assign acc_wdat = host_sel ? host_dat_i : lane_wdat[lane_pick];

    always_ff @(posedge clk) begin
        if (host_sel || lane_sel) begin
            if (acc_we) begin
                mem[acc_adr] <= acc_wdat;
            end
            rd_q <= mem[acc_adr];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            host_ack_q <= 1'b0;
            lane_ack_q <= '0;
            rr_q       <= '0;
        end else begin
            host_ack_q <= host_sel;
            lane_ack_q <= '0;
            if (lane_sel) begin
                lane_ack_q[lane_pick] <= 1'b1;
                rr_q <= (lane_pick == RW'(NM - 1)) ? '0 : lane_pick + 1'b1;
            end
        end
    end

    assign host_dat_o = rd_q;
    assign host_ack_o = host_ack_q;

    a_one_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({host_ack_q, lane_ack_q}));

endmodule

// File: verilog/ifmap_lane_ctrl.sv
`timescale 1ns/100ps

module ifmap_lane_ctrl import l3c_pkg::*; #(
    parameter int LANE_IDX = 0
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      job_start_i,
    input  glb_addr_t ifmap_base_i,
    input  cnt_t      len_i,
    input  logic      fifo_afull_i,
    output logic      fifo_push_o,
    output word_t     fifo_wdata_o,
    glb_wb_if.master  bus
);

    glb_addr_t addr_q;
    cnt_t      remain_q;   // reads still to issue
    logic      req_q;      // cyc and stb

    assign bus.cyc   = req_q;
    assign bus.stb   = req_q;
    assign bus.we    = 1'b0;
    assign bus.adr   = addr_q;
    assign bus.dat_w = '0;     // read only master

    // ack data goes straight into the fifo
    assign fifo_push_o  = req_q & bus.ack;
    assign fifo_wdata_o = bus.dat_r;

    always_ff @(posedge clk) begin
        if (job_start_i) begin
            addr_q <= lane_region(ifmap_base_i, LANE_IDX, len_i);
        end else if (req_q && bus.ack) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q    <= 1'b0;
            remain_q <= '0;
        end else if (job_start_i) begin
            // fifo is empty at job start
            req_q    <= (len_i != '0);
            remain_q <= len_i;
        end else if (req_q) begin
            if (bus.ack) begin
                req_q    <= 1'b0;   // afull is rechecked next cycle
                remain_q <= remain_q - 1'b1;
            end
        end else if ((remain_q != '0) && !fifo_afull_i) begin
            req_q <= 1'b1;
        end
    end

    // a read is only issued below afull and only pops happen meanwhile
    a_no_push_afull: assert property (@(posedge clk) disable iff (!arst_n_i)
        fifo_push_o |-> !fifo_afull_i);

endmodule

// File: verilog/opsum_lane_ctrl.sv
`timescale 1ns/100ps

module opsum_lane_ctrl import l3c_pkg::*; #(
    parameter int LANE_IDX = 0
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      job_start_i,
    input  glb_addr_t opsum_base_i,
    input  cnt_t      len_i,
    input  logic      fifo_empty_i,
    input  word_t     fifo_rdata_i,
    output logic      fifo_pop_o,
    output logic      lane_done_o,
    glb_wb_if.master  bus
);

    glb_addr_t addr_q;
    cnt_t      remain_q;
    logic      req_q;
    logic      done_q;

    assign bus.cyc   = req_q;
    assign bus.stb   = req_q;
    assign bus.we    = 1'b1;
    assign bus.adr   = addr_q;
    assign bus.dat_w = fifo_rdata_i;  // head stays put until our pop

    assign fifo_pop_o  = req_q & bus.ack;
    assign lane_done_o = done_q;

    always_ff @(posedge clk) begin
        if (job_start_i) begin
            addr_q <= lane_region(opsum_base_i, LANE_IDX, len_i);
        end else if (req_q && bus.ack) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q    <= 1'b0;
            remain_q <= '0;
            done_q   <= 1'b0;
        end else if (job_start_i) begin
            req_q    <= 1'b0;
            remain_q <= len_i;
            done_q   <= (len_i == '0);  // empty job
        end else if (req_q) begin
            if (bus.ack) begin
                req_q    <= 1'b0;
                remain_q <= remain_q - 1'b1;
                if (remain_q == cnt_t'(1)) begin
                    done_q <= 1'b1;   // last word written
                end
            end
        end else if ((remain_q != '0) && !fifo_empty_i) begin
            req_q <= 1'b1;
        end
    end

endmodule

// File: verilog/pe_array.sv
`timescale 1ns/100ps

module pe_array import l3c_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   move_i,
    input  scale_t scale_i,
    input  word_t  ifmap_data_i [NUM_LANES],
    output logic   opsum_push_o,
    output word_t  opsum_data_o [NUM_LANES]
);

    logic push_q;

    // all lanes step together on move
    always_ff @(posedge clk) begin
        if (move_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                opsum_data_o[l] <= ifmap_data_i[l] * word_t'(scale_i);  // low 32 bits
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_q <= 1'b0;
        end else begin
            push_q <= move_i;
        end
    end

    assign opsum_push_o = push_q;

endmodule

// File: verilog/l3c_fifo_ctrl.sv
`timescale 1ns/100ps

module l3c_fifo_ctrl import l3c_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  cnt_t                 len_i,
    input  logic [NUM_LANES-1:0] ifmap_empty_i,
    input  logic [NUM_LANES-1:0] opsum_afull_i,
    input  logic [NUM_LANES-1:0] lane_done_i,
    output logic                 job_start_o,
    output logic                 move_o,
    output logic                 busy_o,
    output logic                 done_o
);

    ctrl_state_e state_q;
    cnt_t        len_q;
    cnt_t        move_cnt_q;
    logic        job_start_q;
    logic        done_q;
    logic        lanes_ready;

    // every ifmap fifo has a word and every opsum fifo has room for one more
    assign lanes_ready = !(|ifmap_empty_i) && !(|opsum_afull_i);
    assign move_o      = (state_q == RUN) && (move_cnt_q != len_q) && lanes_ready;
    assign busy_o      = (state_q != IDLE);
    assign job_start_o = job_start_q;
    assign done_o      = done_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            len_q       <= '0;
            move_cnt_q  <= '0;
            job_start_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            job_start_q <= 1'b0;
            done_q      <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q     <= RUN;
                        len_q       <= len_i;
                        move_cnt_q  <= '0;
                        job_start_q <= 1'b1;   // lanes latch their regions
                    end
                end
                RUN: begin
                    if (move_o) begin
                        move_cnt_q <= move_cnt_q + 1'b1;
                    end
                    if (move_cnt_q == len_q) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    // last products still on their way to the glb
                    if (&lane_done_i) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_move_needs_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        move_o |-> !(|ifmap_empty_i));

endmodule

// File: verilog/l3c_top.sv
`timescale 1ns/100ps

module l3c_top import l3c_pkg::*; #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,
    input  glb_addr_t ifmap_base_i,
    input  glb_addr_t opsum_base_i,
    input  cnt_t      len_i,
    input  scale_t    scale_i,
    input  logic      host_cyc_i,
    input  logic      host_stb_i,
    input  logic      host_we_i,
    input  glb_addr_t host_adr_i,
    input  word_t     host_dat_i,
    output word_t     host_dat_o,
    output logic      host_ack_o,
    output logic      busy_o,
    output logic      done_o
);

    logic                 job_start;
    logic                 move;      // pops all ifmap fifos
    logic                 pe_push;   // pushes all opsum fifos
    logic [NUM_LANES-1:0] ifmap_empty;
    logic [NUM_LANES-1:0] opsum_afull;
    logic [NUM_LANES-1:0] lane_done;
    word_t                ifmap_head [NUM_LANES];
    word_t                opsum_data [NUM_LANES];

    // 0..N-1 ifmap readers, N..2N-1 opsum writers
    glb_wb_if lane_bus [2*NUM_LANES] ();

    glb_sram_arb #(
        .NUM_LANES (NUM_LANES)
    ) i_glb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .host_cyc_i (host_cyc_i),
        .host_stb_i (host_stb_i),
        .host_we_i  (host_we_i),
        .host_adr_i (host_adr_i),
        .host_dat_i (host_dat_i),
        .host_dat_o (host_dat_o),
        .host_ack_o (host_ack_o),
        .lane_bus   (lane_bus)
    );

    l3c_fifo_ctrl #(
        .NUM_LANES (NUM_LANES)
    ) i_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .start_i       (start_i),
        .len_i         (len_i),
        .ifmap_empty_i (ifmap_empty),
        .opsum_afull_i (opsum_afull),
        .lane_done_i   (lane_done),
        .job_start_o   (job_start),
        .move_o        (move),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    pe_array #(
        .NUM_LANES (NUM_LANES)
    ) i_pe (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .move_i       (move),
        .scale_i      (scale_i),
        .ifmap_data_i (ifmap_head),
        .opsum_push_o (pe_push),
        .opsum_data_o (opsum_data)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic  ifmap_push;
        word_t ifmap_wdata;
        logic  ifmap_afull;
        logic  opsum_pop;
        word_t opsum_head;
        logic  opsum_empty;

        ifmap_lane_ctrl #(
            .LANE_IDX (l)
        ) i_ifmap_ctrl (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .job_start_i  (job_start),
            .ifmap_base_i (ifmap_base_i),
            .len_i        (len_i),
            .fifo_afull_i (ifmap_afull),
            .fifo_push_o  (ifmap_push),
            .fifo_wdata_o (ifmap_wdata),
            .bus          (lane_bus[l])
        );

        lane_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) i_ifmap_fifo (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .push_i   (ifmap_push),
            .wdata_i  (ifmap_wdata),
            .pop_i    (move),
            .rdata_o  (ifmap_head[l]),
            .empty_o  (ifmap_empty[l]),
            .afull_o  (ifmap_afull)
        );

        lane_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) i_opsum_fifo (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .push_i   (pe_push),
            .wdata_i  (opsum_data[l]),
            .pop_i    (opsum_pop),
            .rdata_o  (opsum_head),
            .empty_o  (opsum_empty),
            .afull_o  (opsum_afull[l])
        );

        opsum_lane_ctrl #(
            .LANE_IDX (l)
        ) i_opsum_ctrl (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .job_start_i  (job_start),
            .opsum_base_i (opsum_base_i),
            .len_i        (len_i),
            .fifo_empty_i (opsum_empty),
            .fifo_rdata_i (opsum_head),
            .fifo_pop_o   (opsum_pop),
            .lane_done_o  (lane_done[l]),
            .bus          (lane_bus[NUM_LANES + l])
        );
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;   // released just after an edge
    end

endmodule

// File: test/tb_l3c_top.sv
`timescale 1ns/100ps

module tb_l3c_top import l3c_pkg::*; ();

    localparam int        NUM_LANES    = 4;
    localparam int        FIFO_DEPTH   = 4;
    localparam int        MAX_PAT      = 16;
    localparam int        ACK_TIMEOUT  = 50;     // cycles per host access
    localparam int        JOB_TIMEOUT  = 5000;   // cycles per job
    localparam glb_addr_t NOISE_BASE   = 10'h380;
    localparam int        NOISE_WORDS  = 64;

    logic      clk;
    logic      arst_n;
    logic      start_i;
    glb_addr_t ifmap_base_i;
    glb_addr_t opsum_base_i;
    cnt_t      len_i;
    scale_t    scale_i;
    logic      host_cyc_i;
    logic      host_stb_i;
    logic      host_we_i;
    glb_addr_t host_adr_i;
    word_t     host_dat_i;
    word_t     host_dat_o;
    logic      host_ack_o;
    logic      busy_o;
    logic      done_o;

    int unsigned errors    = 0;
    int unsigned done_cnt  = 0;
    logic        done_prev = 1'b0;
    logic        busy_prev = 1'b0;
    word_t       pat_mem [0:8*MAX_PAT];   // word 0 holds the job count

    tb_clk_gen #(
        .PERIOD     (100),
        .RST_CYCLES (5)
    ) i_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    l3c_top #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .start_i      (start_i),
        .ifmap_base_i (ifmap_base_i),
        .opsum_base_i (opsum_base_i),
        .len_i        (len_i),
        .scale_i      (scale_i),
        .host_cyc_i   (host_cyc_i),
        .host_stb_i   (host_stb_i),
        .host_we_i    (host_we_i),
        .host_adr_i   (host_adr_i),
        .host_dat_i   (host_dat_i),
        .host_dat_o   (host_dat_o),
        .host_ack_o   (host_ack_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    task automatic check_val(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // known contents for untouched and poisoned words
    function automatic word_t fill_word(glb_addr_t adr);
        return 32'hA5C3_0000 ^ (word_t'(adr) * 32'h9E37_79B1);
    endfunction

    // one wishbone classic cycle on the host port
    task automatic host_access(input logic we, input glb_addr_t adr, input word_t wdat,
                               output word_t rdat);
        int unsigned n;
        n = 0;
        @(posedge clk);
        host_cyc_i <= 1'b1;
        host_stb_i <= 1'b1;
        host_we_i  <= we;
        host_adr_i <= adr;
        host_dat_i <= wdat;
        @(negedge clk);
        while (!host_ack_o && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (host_ack_o) begin
            rdat = host_dat_o;
        end else begin
            rdat = 'x;
            report_error($sformatf("host access to %h got no ack", adr));
        end
        @(posedge clk);
        host_cyc_i <= 1'b0;
        host_stb_i <= 1'b0;
        host_we_i  <= 1'b0;
    endtask

    task automatic host_write(input glb_addr_t adr, input word_t dat);
        word_t unused;
        host_access(1'b1, adr, dat, unused);
    endtask

    task automatic host_read(input glb_addr_t adr, output word_t dat);
        host_access(1'b0, adr, '0, dat);
    endtask

    // done must be a single cycle pulse that ends busy
    always @(negedge clk) begin
        if (arst_n) begin
            if (done_o) begin
                done_cnt++;
                if (done_prev)
                    report_error("done_o stayed high for more than one cycle");
                if (!busy_prev)
                    report_error("done_o came while no job was busy");
                if (busy_o)
                    report_error("busy_o still high in the done_o cycle");
            end
            if (busy_prev && !busy_o && !done_o)
                report_error("busy_o fell without done_o");
        end
        done_prev = done_o;
        busy_prev = busy_o;
    end

    task automatic run_job(input int unsigned p, output logic ok);
        int unsigned base;
        int unsigned total;
        int unsigned k;
        int unsigned n;
        int unsigned dones;
        cnt_t        len;
        scale_t      scale;
        glb_addr_t   ifb;
        glb_addr_t   opb;
        glb_addr_t   nadr;
        word_t       dstart;
        word_t       dstep;
        word_t       csum;
        word_t       got;
        word_t       xsum;
        logic        noise;

        base   = 1 + p * 8;
        len    = cnt_t'(pat_mem[base]);
        scale  = scale_t'(pat_mem[base + 1]);
        ifb    = glb_addr_t'(pat_mem[base + 2]);
        opb    = glb_addr_t'(pat_mem[base + 3]);
        dstart = pat_mem[base + 4];
        dstep  = pat_mem[base + 5];
        noise  = pat_mem[base + 6][0];
        csum   = pat_mem[base + 7];
        total  = NUM_LANES * len;
        ok     = 1'b1;

        // input words, and poison where results will land
        for (k = 0; k < total; k++) begin
            host_write(ifb + glb_addr_t'(k), dstart + dstep * word_t'(k));
            host_write(opb + glb_addr_t'(k), fill_word(opb + glb_addr_t'(k)));
        end

        dones = done_cnt;
        @(posedge clk);
        start_i      <= 1'b1;
        len_i        <= len;
        scale_i      <= scale;
        ifmap_base_i <= ifb;
        opsum_base_i <= opb;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        check_val("busy_o after start", 32'd1, busy_o);

        n = 0;
        while (done_cnt == dones && n < JOB_TIMEOUT) begin
            if (noise && ($urandom % 4) == 0) begin
                nadr = NOISE_BASE + glb_addr_t'($urandom % NOISE_WORDS);
                host_read(nadr, got);
                check_val($sformatf("host_dat_o noise read %h", nadr), fill_word(nadr), got);
                n += 3;
            end else begin
                @(posedge clk);
                n++;
            end
        end

        if (done_cnt == dones) begin
            report_error($sformatf("job %0d timed out waiting for done_o", p));
            ok = 1'b0;
        end else begin
            xsum = '0;
            for (k = 0; k < total; k++) begin
                host_read(opb + glb_addr_t'(k), got);
                check_val($sformatf("host_dat_o opsum lane %0d word %0d", k / len, k % len),
                          (dstart + dstep * word_t'(k)) * word_t'(scale), got);
                xsum ^= got;
            end
            check_val($sformatf("job %0d checksum", p), csum, xsum);
        end
    endtask

    initial begin
        int unsigned n;
        int unsigned p;
        int unsigned npat;
        int unsigned jobs;
        word_t       got;
        logic        ok;

        start_i      = 1'b0;
        ifmap_base_i = '0;
        opsum_base_i = '0;
        len_i        = '0;
        scale_i      = '0;
        host_cyc_i   = 1'b0;
        host_stb_i   = 1'b0;
        host_we_i    = 1'b0;
        host_adr_i   = '0;
        host_dat_i   = '0;
        jobs         = 0;
        void'($urandom(32'h4f9e));
        $readmemh("test/l3c_patterns.txt", pat_mem);

        n = 0;
        while (!arst_n && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n)
            report_error("reset was never released");
        @(negedge clk);
        check_val("busy_o after reset", 32'd0, busy_o);
        check_val("done_o after reset", 32'd0, done_o);
        check_val("host_ack_o after reset", 32'd0, host_ack_o);

        host_write(10'h3F0, fill_word(10'h3F0));
        host_read(10'h3F0, got);
        check_val("host_dat_o readback", fill_word(10'h3F0), got);

        for (n = 0; n < NOISE_WORDS; n++) begin
            host_write(NOISE_BASE + glb_addr_t'(n), fill_word(NOISE_BASE + glb_addr_t'(n)));
        end

        npat = pat_mem[0];
        if ($isunknown(pat_mem[0]) || npat == 0 || npat > MAX_PAT) begin
            report_error("pattern file is missing or holds no valid job count");
            npat = 0;
        end
        ok = 1'b1;
        for (p = 0; p < npat && ok; p++) begin
            run_job(p, ok);
            jobs++;
        end

        $display("Jobs run: %0d, errors: %0d", jobs, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: l3c_top.f
verilog/l3c_pkg.sv
verilog/glb_wb_if.sv
verilog/lane_fifo.sv
verilog/glb_sram_arb.sv
verilog/ifmap_lane_ctrl.sv
verilog/opsum_lane_ctrl.sv
verilog/pe_array.sv
verilog/l3c_fifo_ctrl.sv
verilog/l3c_top.sv
test/tb_clk_gen.sv
test/tb_l3c_top.sv

// File: test/l3c_patterns.txt
// first value is the number of jobs, then one job per line, all hex
// len scale ifmap_base opsum_base data_start data_step host_noise xor_checksum
5
01 0003 000 100 00000005 00000002 0 00000020
0A 0004 040 140 00000001 00000001 0 000000A0
06 0010 080 180 00000100 00000100 1 00018000
01 FFFF 0D0 1D0 12345678 11111111 1 0000C0CC
20 0002 200 280 00000001 00000001 1 00000100
